// ==== hdl/rvCfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data path and address width
`define XLEN 32

// Architectural integer registers including x0
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000 // First fetch address

// Debug bus byte address that returns the PC
`define PC_DEBUG_ADDR 8'h80

`endif

// ==== hdl/rvIsaPkg.sv ====
`default_nettype none

`include "rvCfg.svh"

package rvIsaPkg;

	typedef logic [`XLEN-1:0] word_t; // Data or address word
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;
	typedef logic [2:0] func3_t;
	typedef logic [6:0] func7_t;

	// Major opcodes handled by this core
	typedef enum logic [6:0]
	{
		opImm   = 7'b0010011,
		opOp    = 7'b0110011,
		opLui   = 7'b0110111,
		opAuipc = 7'b0010111,
		opJal   = 7'b1101111,
		opJalr  = 7'b1100111,
		opBranch = 7'b1100011
	} opcode_t;

	typedef enum logic [3:0]
	{
		aluAdd, aluSub, aluSll, aluSlt, aluSltu,
		aluXor, aluSrl, aluSra, aluOr, aluAnd
	} aluOp_t;

	// How the PC moves after an instruction
	typedef enum logic [2:0]
	{
		pcNext, pcBranch, pcJal, pcJalr
	} pcOp_t;

	typedef struct packed
	{
		opcode_t opcode;
		func3_t  func3;
		func7_t  func7;
		regIdx_t rd;
		word_t   rs1Val;
		word_t   rs2Val;
		word_t   imm;
		word_t   pc; // Address of this instruction
	} decoded_t;

	typedef struct packed
	{
		logic    en;
		regIdx_t rd;
		word_t   data;
	} writeBack_t;

endpackage

`default_nettype wire

// ==== hdl/apbPkg.sv ====
`default_nettype none

`include "rvCfg.svh"

package apbPkg;

	typedef logic [7:0] apbAddr_t; // Byte address on the debug bus

	typedef struct packed
	{
		logic              psel;
		logic              penable;
		logic              pwrite;
		apbAddr_t          paddr;
		logic [`XLEN-1:0]  pwdata;
	} apbReq_t;

	typedef struct packed
	{
		logic              pready;
		logic [`XLEN-1:0]  prdata;
		logic              pslverr;
	} apbRsp_t;

	// Slave side transfer phases
	typedef enum logic
	{
		apbIdle,
		apbAccess
	} apbState_t;

endpackage

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rvCfg.svh"

module regFile
	import rvIsaPkg::*;
(
	input  wire logic       clk,
	input  wire logic       rstN,
	input  wire regIdx_t    rs1,
	input  wire regIdx_t    rs2,
	output word_t           rs1Data,
	output word_t           rs2Data,
	input  wire regIdx_t    dbgIdx,
	output word_t           dbgData,
	input  wire writeBack_t writeBack
);

	word_t regs [`REG_COUNT];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeBack.en && writeBack.rd != '0) // x0 stays zero
		begin
			regs[writeBack.rd] <= writeBack.data;
		end
	end

	// Asynchronous read ports
	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];
	assign dbgData = regs[dbgIdx]; // Debug read port

endmodule

`default_nettype wire

// ==== hdl/execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rvCfg.svh"

module execUnit
	import rvIsaPkg::*;
(
	input  wire decoded_t decoded,
	input  wire logic     executing,
	output writeBack_t    writeBack,
	output word_t         pcWriteData,
	output pcOp_t         pcOp
);

	aluOp_t aluOp;
	word_t  opA;
	word_t  opB;
	word_t  aluResult;
	word_t  linkAddr;
	word_t  rdData;
	logic   writesRd;
	logic   taken;
	logic [4:0] shamt;

	assign opA   = decoded.rs1Val;
	assign opB   = (decoded.opcode == opOp) ? decoded.rs2Val : decoded.imm;
	assign shamt = opB[4:0];
	assign linkAddr = decoded.pc + word_t'(4); // Return address for jumps

	// func7 bit 5 selects sub and sra
	always_comb
	begin
		aluOp = aluAdd;
		if (decoded.opcode == opOp || decoded.opcode == opImm)
		begin
			case (decoded.func3)
				3'b000: aluOp = (decoded.opcode == opOp && decoded.func7[5]) ? aluSub : aluAdd;
				3'b001: aluOp = aluSll;
				3'b010: aluOp = aluSlt;
				3'b011: aluOp = aluSltu;
				3'b100: aluOp = aluXor;
				3'b101: aluOp = decoded.func7[5] ? aluSra : aluSrl;
				3'b110: aluOp = aluOr;
				default: aluOp = aluAnd;
			endcase
		end
	end

	always_comb
	begin
		case (aluOp)
			aluSub:  aluResult = opA - opB;
			aluSll:  aluResult = opA << shamt;
			aluSlt:  aluResult = word_t'($signed(opA) < $signed(opB));
			aluSltu: aluResult = word_t'(opA < opB);
			aluXor:  aluResult = opA ^ opB;
			aluSrl:  aluResult = opA >> shamt;
			aluSra:  aluResult = word_t'($signed(opA) >>> shamt);
			aluOr:   aluResult = opA | opB;
			aluAnd:  aluResult = opA & opB;
			default: aluResult = opA + opB; // Also the JALR target sum
		endcase
	end

	// Branch conditions on the two register operands
	always_comb
	begin
		case (decoded.func3)
			3'b000:  taken = decoded.rs1Val == decoded.rs2Val;
			3'b001:  taken = decoded.rs1Val != decoded.rs2Val;
			3'b100:  taken = $signed(decoded.rs1Val) < $signed(decoded.rs2Val);
			3'b101:  taken = $signed(decoded.rs1Val) >= $signed(decoded.rs2Val);
			3'b110:  taken = decoded.rs1Val < decoded.rs2Val;
			3'b111:  taken = decoded.rs1Val >= decoded.rs2Val;
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		writesRd    = 1'b1;
		rdData      = aluResult;
		pcOp        = pcNext;
		pcWriteData = decoded.pc + decoded.imm;
		case (decoded.opcode)
			opLui:   rdData = decoded.imm;
			opAuipc: rdData = decoded.pc + decoded.imm;
			opJal:
			begin
				rdData = linkAddr;
				pcOp   = pcJal;
			end
			opJalr:
			begin
				rdData      = linkAddr;
				pcOp        = pcJalr;
				pcWriteData = {aluResult[`XLEN-1:1], 1'b0};
			end
			opBranch:
			begin
				writesRd = 1'b0;
				pcOp     = taken ? pcBranch : pcNext;
			end
			opImm, opOp: rdData = aluResult;
			default: writesRd = 1'b0; // Unknown opcode retires as a no-op
		endcase
	end

	assign writeBack = '{en: executing && writesRd, rd: decoded.rd, data: rdData};

endmodule

`default_nettype wire

// ==== hdl/instrBreakdown.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrBreakdown
	import rvIsaPkg::*;
(
	input  wire logic    clk,
	input  wire logic    rstN,
	input  wire word_t   instr,
	input  wire logic    accept,
	input  wire word_t   pcReadData,
	input  wire logic    executing,
	input  wire regIdx_t dbgIdx,
	output word_t        dbgData,
	output word_t        pcWriteData,
	output pcOp_t        pcOp
);

	opcode_t    opcode;
	func3_t     func3;
	func7_t     func7;
	regIdx_t    rd;
	regIdx_t    rs1;
	regIdx_t    rs2;
	word_t      imm;
	word_t      rs1Data;
	word_t      rs2Data;
	decoded_t   decodedQ;
	writeBack_t writeBack;

	// Fixed RV32 field positions
	assign opcode = opcode_t'(instr[6:0]);
	assign func3  = instr[14:12];
	assign func7  = instr[31:25];
	assign rd     = instr[11:7];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	always_comb
	begin
		case (opcode)
			opImm, opJalr:
			begin
				// Shift amounts keep the raw field so func7 stays visible
				if (opcode == opImm && (func3 == 3'b001 || func3 == 3'b101))
					imm = {20'b0, instr[31:20]};
				else
					imm = {{20{instr[31]}}, instr[31:20]};
			end
			opBranch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			opLui, opAuipc: imm = {instr[31:12], 12'b0};
			opJal: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = '0; // R-type and unknown opcodes
		endcase
	end

	regFile rf
	(
		.clk       (clk),
		.rstN      (rstN),
		.rs1       (rs1),
		.rs2       (rs2),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data),
		.dbgIdx    (dbgIdx),
		.dbgData   (dbgData),
		.writeBack (writeBack)
	);

	// Operand register loaded once per fetched instruction
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			decodedQ <= '{opcode: opcode, func3: func3, func7: func7, rd: rd,
				rs1Val: rs1Data, rs2Val: rs2Data, imm: imm, pc: pcReadData};
		end
	end

	execUnit ex
	(
		.decoded     (decodedQ),
		.executing   (executing),
		.writeBack   (writeBack),
		.pcWriteData (pcWriteData),
		.pcOp        (pcOp)
	);

endmodule

`default_nettype wire

// ==== hdl/pcUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rvCfg.svh"

module pcUnit
	import rvIsaPkg::*;
(
	input  wire logic  clk,
	input  wire logic  rstN,
	input  wire pcOp_t pcOp,
	input  wire word_t pcWriteData,
	input  wire logic  instrValid,
	output logic       fetchReq,
	output word_t      fetchAddr,
	output logic       accept,
	output logic       executing
);

	typedef enum logic
	{
		stFetch,
		stExecute
	} pcState_t;

	pcState_t state;
	word_t    pc;

	assign accept    = fetchReq && instrValid; // Stray instrValid is ignored
	assign executing = state == stExecute;
	assign fetchAddr = pc;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state    <= stFetch;
			fetchReq <= 1'b0;
			pc       <= `RESET_PC;
		end
		else if (state == stFetch)
		begin
			fetchReq <= !accept; // Hold the request until the word arrives
			if (accept)
				state <= stExecute;
		end
		else
		begin
			pc       <= (pcOp == pcNext) ? pc + word_t'(4) : pcWriteData;
			fetchReq <= 1'b1;
			state    <= stFetch;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/apbDebug.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rvCfg.svh"

module apbDebug
	import rvIsaPkg::*, apbPkg::*;
(
	input  wire logic    clk,
	input  wire logic    rstN,
	input  wire apbReq_t apbReq,
	output apbRsp_t      apbRsp,
	output regIdx_t      dbgIdx,
	input  wire word_t   dbgData,
	input  wire word_t   pc
);

	apbState_t state;
	logic      setup;
	logic      regHit;
	logic      pcHit;

	assign setup  = apbReq.psel && !apbReq.penable;
	assign dbgIdx = regIdx_t'(apbReq.paddr >> 2); // Word index of xn

	// Word aligned register window and the PC slot
	assign regHit = apbReq.paddr < apbAddr_t'(4 * `REG_COUNT) && apbReq.paddr[1:0] == 2'b00;
	assign pcHit  = apbReq.paddr == `PC_DEBUG_ADDR;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state  <= apbIdle;
			apbRsp <= '0;
		end
		else if (state == apbIdle && setup)
		begin
			// Response ready for the access cycle without wait states
			state          <= apbAccess;
			apbRsp.pready  <= 1'b1;
			apbRsp.pslverr <= apbReq.pwrite || !(regHit || pcHit);
			if (apbReq.pwrite)
				apbRsp.prdata <= '0;
			else if (regHit)
				apbRsp.prdata <= dbgData;
			else if (pcHit)
				apbRsp.prdata <= pc;
			else
				apbRsp.prdata <= '0;
		end
		else
		begin
			state  <= apbIdle;
			apbRsp <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/coreTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module coreTop
	import rvIsaPkg::*, apbPkg::*;
(
	input  wire logic    clk,
	input  wire logic    rstN,
	output logic         fetchReq,
	output word_t        fetchAddr,
	input  wire word_t   instr,
	input  wire logic    instrValid,
	input  wire apbReq_t apbReq,
	output apbRsp_t      apbRsp
);

	pcOp_t   pcOp;
	word_t   pcWriteData;
	logic    accept;
	logic    executing;
	regIdx_t dbgIdx;
	word_t   dbgData;

	pcUnit pcu
	(
		.clk         (clk),
		.rstN        (rstN),
		.pcOp        (pcOp),
		.pcWriteData (pcWriteData),
		.instrValid  (instrValid),
		.fetchReq    (fetchReq),
		.fetchAddr   (fetchAddr),
		.accept      (accept),
		.executing   (executing)
	);

	// fetchAddr doubles as the current PC
	instrBreakdown decode
	(
		.clk         (clk),
		.rstN        (rstN),
		.instr       (instr),
		.accept      (accept),
		.pcReadData  (fetchAddr),
		.executing   (executing),
		.dbgIdx      (dbgIdx),
		.dbgData     (dbgData),
		.pcWriteData (pcWriteData),
		.pcOp        (pcOp)
	);

	apbDebug dbg
	(
		.clk     (clk),
		.rstN    (rstN),
		.apbReq  (apbReq),
		.apbRsp  (apbRsp),
		.dbgIdx  (dbgIdx),
		.dbgData (dbgData),
		.pc      (fetchAddr)
	);

endmodule

`default_nettype wire

// ==== bench/coreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rvCfg.svh"

module coreTb
	import rvIsaPkg::*, apbPkg::*;
();

	logic    clk;
	logic    rstN;
	logic    fetchReq;
	word_t   fetchAddr;
	word_t   instr;
	logic    instrValid;
	apbReq_t apbReq;
	apbRsp_t apbRsp;

	word_t testData [512]; // Flat test stream from coreTests.txt
	word_t prog [64];      // Word addressed instruction memory
	word_t endAddr;
	word_t rngState;
	int    waitLeft;
	int    errors;
	int    checks;
	int    cycleCount;
	int    cycleLimit;

	coreTop dut
	(
		.clk        (clk),
		.rstN       (rstN),
		.fetchReq   (fetchReq),
		.fetchAddr  (fetchAddr),
		.instr      (instr),
		.instrValid (instrValid),
		.apbReq     (apbReq),
		.apbRsp     (apbRsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic word_t xorshift(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Instruction memory answers fetches after 0 to 3 idle cycles
	always @(posedge clk)
	begin
		instrValid <= 1'b0;
		if (rstN && fetchReq && !instrValid && fetchAddr != endAddr)
		begin
			if (waitLeft == 0)
			begin
				instr      <= prog[fetchAddr[7:2]];
				instrValid <= 1'b1;
				rngState = xorshift(rngState);
				waitLeft <= int'(rngState[1:0]);
			end
			else
			begin
				waitLeft <= waitLeft - 1;
			end
		end
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit)
		begin
			$display("run stopped: the cycle limit of %0d was reached before the tests ended",
				cycleLimit);
			$display("test failed");
			$finish;
		end
	end

	task automatic compareValue(input string name, input word_t got, input word_t expected);
		checks++;
		if (got !== expected)
		begin
			$display("mismatch %s: got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	// One APB transfer through its setup and access phases
	task automatic apbTransfer(input logic write, input apbAddr_t addr, input word_t wdata,
		output word_t rdata, output logic err);
		int waits;
		waits = 0;
		@(posedge clk);
		apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clk);
		apbReq.penable <= 1'b1;
		@(negedge clk);
		while (!apbRsp.pready && waits < 4)
		begin
			@(negedge clk);
			waits++;
		end
		if (!apbRsp.pready)
		begin
			$display("APB transfer at address %h never saw pready", addr);
			errors++;
		end
		rdata = apbRsp.prdata;
		err   = apbRsp.pslverr;
		@(posedge clk);
		apbReq <= '0;
	endtask

	task automatic runCase(input int caseNum, input int base, output int nextBase);
		int    n;
		int    k;
		int    idx;
		int    errsBefore;
		word_t rdata;
		logic  err;
		n = int'(testData[base]);
		errsBefore = errors;
		@(negedge clk);
		for (int i = 0; i < 64; i++)
			prog[i] = (i < n) ? testData[base + 1 + i] : '0;
		endAddr = testData[base + n + 1];
		@(posedge clk);
		rstN <= 1'b0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		do
			@(negedge clk);
		while (!(fetchReq && fetchAddr == endAddr));
		k = int'(testData[base + n + 2]);
		for (int j = 0; j < k; j++)
		begin
			idx = int'(testData[base + n + 3 + 2 * j]);
			apbTransfer(1'b0, apbAddr_t'(idx * 4), '0, rdata, err);
			compareValue($sformatf("x%0d", idx), rdata, testData[base + n + 4 + 2 * j]);
			compareValue("pslverr", word_t'(err), '0);
		end
		apbTransfer(1'b0, `PC_DEBUG_ADDR, '0, rdata, err);
		compareValue("pc", rdata, testData[base + n + 3 + 2 * k]);
		compareValue("pslverr", word_t'(err), '0);
		nextBase = base + n + 4 + 2 * k;
		$display("case %0d: %0d errors", caseNum, errors - errsBefore);
	endtask

	initial
	begin
		int    p;
		int    next;
		int    total;
		int    cases;
		word_t rdata;
		logic  err;
		rstN       = 1'b0;
		instr      = '0;
		instrValid = 1'b0;
		apbReq     = '0;
		endAddr    = '0;
		rngState   = 32'd62;
		waitLeft   = 0;
		errors     = 0;
		checks     = 0;
		cycleCount = 0;
		cycleLimit = 0;
		$readmemh("bench/coreTests.txt", testData);

		// Size the cycle limit from the program lengths
		p = 0;
		total = 0;
		cases = 0;
		while (testData[p] != 0)
		begin
			total += int'(testData[p]);
			cases++;
			p = p + int'(testData[p]) + 4 + 2 * int'(testData[p + int'(testData[p]) + 2]);
		end
		cycleLimit = total * 4 * 7 + cases * 400 + 200;

		p = 0;
		for (int c = 1; c <= cases; c++)
		begin
			runCase(c, p, next);
			p = next;
		end

		// Debug port error responses
		apbTransfer(1'b1, 8'h04, 32'h1234_5678, rdata, err);
		compareValue("pslverr", word_t'(err), 32'd1);
		compareValue("prdata", rdata, '0);
		apbTransfer(1'b0, 8'h84, '0, rdata, err);
		compareValue("pslverr", word_t'(err), 32'd1);
		compareValue("prdata", rdata, '0);
		$display("case %0d: debug port errors done", cases + 1);

		$display("%0d cases, %0d checks, %0d errors", cases + 1, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/coreTests.txt ====
// Per test: word count N, N program words from address 0, end address, check count K,
// K pairs of register index and value, expected PC. A count of 0 ends the list
// alu: register and immediate arithmetic, shifts, slt and sltu
0a
FFB00093 00300113 402081B3 4020D233 0020D2B3 0020A333 0020B3B3 4010D413 00411493 0F00C513
28
0a
01 FFFFFFFB 02 00000003 03 FFFFFFF8 04 FFFFFFFF 05 1FFFFFFF
06 00000001 07 00000000 08 FFFFFFFD 09 00000030 0a FFFFFF0B
28
// upper: LUI, AUIPC and writes to x0
05
123450B7 00001117 00500013 001001B3 ABCDE037
14
04
00 00000000 01 12345000 02 00001004 03 12345000
14
// branch: six conditions, a taken branch skips its addi
0e
FFF00093 00100113 00208463 00100193 00209463 00100213 0020C463
00100293 0020D463 00100313 0020E463 00100393 0020F463 00100413
38
06
03 00000001 04 00000000 05 00000000 06 00000001 07 00000001 08 00000000
38
// jump: JAL then JALR with an odd target
06
00C000EF 00100293 00100313 01108167 00100393 00700193
18
06
01 00000004 02 00000010 03 00000007 05 00000000 06 00000000 07 00000000
18
00

// ==== verilog.f ====
+incdir+hdl
hdl/rvIsaPkg.sv
hdl/apbPkg.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/instrBreakdown.sv
hdl/pcUnit.sv
hdl/apbDebug.sv
hdl/coreTop.sv
bench/coreTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -Wno-fatal -f verilog.f --top-module coreTb -o coreSim \
	> build.log 2>&1 \
	&& ./obj_dir/coreSim > sim.log 2>&1 \
	&& grep -q "^test passed$" sim.log \
	|| { echo "simulation did not pass, see build.log and sim.log"; exit 1; }
echo "simulation passed"
